//--- filelist.f
+incdir+.
hsv_ctrlstatus_pkg.sv
hsv_skid_buffer.sv
hsv_ctrlstatus_regs.sv
hsv_ctrlstatus_counters.sv
hsv_ctrlstatus_readwrite.sv
hsv_ctrlstatus_trap_fsm.sv
hsv_ctrlstatus.sv
tb_ctrlstatus_checker.sv
tb_hsv_ctrlstatus.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_hsv_ctrlstatus -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "ALL CHECKS PASSED" sim.log; then
  exit 0
fi
exit 1

//--- tb_hsv_ctrlstatus.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module tb_hsv_ctrlstatus
  import hsv_ctrlstatus_pkg::*;
();

  // a trap that waits for a running flush still stays well below MAX_OP_CYCLES
  localparam int NUM_OPS = 400;
  localparam int MAX_OP_CYCLES = 50;
  localparam int MAX_CYCLES = NUM_OPS * MAX_OP_CYCLES;

  logic                         clk_core = 1'b0;
  logic                         reset_i;
  logic                         valid_i;
  logic                         ready_o;
  ctrlstatus_data_t             ctrlstatus_data_i;
  logic                         valid_o;
  logic                         ready_i;
  commit_data_t                 commit_data_o;
  logic                         ctrl_trap_i;
  exception_t                   ctrl_trap_cause_i;
  word                          ctrl_trap_value_i;
  word                          ctrl_next_pc_i;
  logic                         ctrl_mode_return_i;
  logic                         ctrl_commit_i;
  logic                         flush_req_o;
  word                          flush_target_o;
  logic [`HSV_FLUSH_STAGES-1:0] flush_acks_i = '0;
  privilege_t                   current_mode_o;

  logic                         req_seen;
  int unsigned                  ack_delay [`HSV_FLUSH_STAGES];
  int unsigned                  cycle_count = 0;
  int                           sent = 0;

  // reference model of the architectural state
  logic       mie_m;
  logic       mpie_m;
  privilege_t mpp_m;
  privilege_t mode_m;
  word        mtvec_m;
  word        mepc_m;
  word        mcause_m;
  word        mtval_m;
  word        mscratch_m;
  word        minstret_m;
  logic       minstret_load;
  word        minstret_next;

  always #2 clk_core = ~clk_core;

  hsv_ctrlstatus dut0 (
    .clk_core(clk_core),
    .reset_i(reset_i),
    .valid_i(valid_i),
    .ready_o(ready_o),
    .ctrlstatus_data_i(ctrlstatus_data_i),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .commit_data_o(commit_data_o),
    .ctrl_trap_i(ctrl_trap_i),
    .ctrl_trap_cause_i(ctrl_trap_cause_i),
    .ctrl_trap_value_i(ctrl_trap_value_i),
    .ctrl_next_pc_i(ctrl_next_pc_i),
    .ctrl_mode_return_i(ctrl_mode_return_i),
    .ctrl_commit_i(ctrl_commit_i),
    .flush_req_o(flush_req_o),
    .flush_target_o(flush_target_o),
    .flush_acks_i(flush_acks_i),
    .current_mode_o(current_mode_o)
  );

  tb_ctrlstatus_checker checker0 (
    .clk_core(clk_core),
    .reset_i(reset_i),
    .valid_o(valid_o),
    .ready_i(ready_i),
    .commit_data_o(commit_data_o),
    .flush_req_o(flush_req_o),
    .flush_acks_i(flush_acks_i)
  );

  // the stages see the request half a cycle late and answer after a random delay
  always @(negedge clk_core) begin
    req_seen <= flush_req_o;
  end

  always @(posedge clk_core) begin
    if (reset_i) begin
      flush_acks_i <= '0;
      for (int i = 0; i < `HSV_FLUSH_STAGES; i++) begin
        ack_delay[i] <= $urandom % 4;
      end
    end else begin
      for (int i = 0; i < `HSV_FLUSH_STAGES; i++) begin
        if (flush_acks_i[i] != req_seen) begin
          if (ack_delay[i] == 0) begin
            flush_acks_i[i] <= req_seen;
            ack_delay[i] <= $urandom % 4;
          end else begin
            ack_delay[i] <= ack_delay[i] - 1;
          end
        end
      end
    end
  end

  always @(posedge clk_core) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      checker0.print_summary();
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic word mstatus_m();
    return {19'b0, mpp_m, 3'b0, mpie_m, 3'b0, mie_m, 3'b0};
  endfunction

  function automatic ctrlstatus_data_t random_insn(input insn_token tok);
    ctrlstatus_data_t d;
    case ($urandom % 10)
      0: d.addr = `HSV_CSR_MSTATUS;
      1: d.addr = `HSV_CSR_MTVEC;
      2: d.addr = `HSV_CSR_MEPC;
      3: d.addr = `HSV_CSR_MCAUSE;
      4: d.addr = `HSV_CSR_MTVAL;
      5: d.addr = `HSV_CSR_MSCRATCH;
      6: d.addr = `HSV_CSR_MCYCLE;
      7: d.addr = `HSV_CSR_MINSTRET;
      8: d.addr = `HSV_CSR_MHARTID;
      // custom range with nothing mapped
      default: d.addr = 12'h7C0 | 12'($urandom % 16);
    endcase
    d.op = csr_op_t'($urandom % 3);
    d.operand = (($urandom % 4) == 0) ? '0 : $urandom;
    // small counter values keep mcycle far from wrapping
    if (d.addr == `HSV_CSR_MCYCLE || d.addr == `HSV_CSR_MINSTRET) begin
      d.operand = d.operand & 32'h00FF_FFFF;
    end
    d.token = tok;
    return d;
  endfunction

  // advance one clock edge and count the commit pulse the DUT sampled at it
  task automatic tick();
    @(posedge clk_core);
    if (minstret_load) begin
      minstret_m = minstret_next;
      minstret_load = 1'b0;
    end else if (ctrl_commit_i) begin
      minstret_m = minstret_m + 1;
    end
    ctrl_commit_i <= ($urandom % 3) == 0;
    ready_i <= ($urandom % 4) != 0;
  endtask

  task automatic model_write(input csr_addr_t addr, input word nv);
    case (addr)
      `HSV_CSR_MSTATUS: begin
        mie_m = nv[3];
        mpie_m = nv[7];
        mpp_m = (nv[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
      end
      `HSV_CSR_MTVEC:    mtvec_m = nv;
      `HSV_CSR_MEPC:     mepc_m = nv;
      `HSV_CSR_MCAUSE:   mcause_m = nv;
      `HSV_CSR_MTVAL:    mtval_m = nv;
      `HSV_CSR_MSCRATCH: mscratch_m = nv;
      `HSV_CSR_MINSTRET: begin
        minstret_load = 1'b1;
        minstret_next = nv;
      end
      default: ;
    endcase
  endtask

  // returns when the request and every ack are low and the FSM is idle again
  task automatic drain_flush();
    logic done;
    done = 1'b0;
    while (!done) begin
      tick();
      @(negedge clk_core);
      done = !flush_req_o && (flush_acks_i == '0);
    end
    tick();
    tick();
  endtask

  // returns once the request has fallen, the stages may still hold their acks
  task automatic await_request_drop();
    logic done;
    done = 1'b0;
    while (!done) begin
      tick();
      @(negedge clk_core);
      done = !flush_req_o;
    end
    tick();
  endtask

  task automatic run_csr();
    ctrlstatus_data_t d;
    logic hit;
    logic wr;
    logic ill;
    word old;
    word nv;
    d = random_insn(insn_token'(sent));
    valid_i <= 1'b1;
    ctrlstatus_data_i <= d;
    @(negedge clk_core);
    while (!ready_o) begin
      tick();
      @(negedge clk_core);
    end
    tick();
    valid_i <= 1'b0;
    // this is the access cycle where the read returns the value before the write
    hit = 1'b1;
    old = '0;
    case (d.addr)
      `HSV_CSR_MSTATUS:  old = mstatus_m();
      `HSV_CSR_MTVEC:    old = mtvec_m;
      `HSV_CSR_MEPC:     old = mepc_m;
      `HSV_CSR_MCAUSE:   old = mcause_m;
      `HSV_CSR_MTVAL:    old = mtval_m;
      `HSV_CSR_MSCRATCH: old = mscratch_m;
      `HSV_CSR_MCYCLE:   old = '0;
      `HSV_CSR_MINSTRET: old = minstret_m;
      `HSV_CSR_MHARTID:  old = `HSV_HART_ID;
      default:           hit = 1'b0;
    endcase
    wr = (d.op == CSR_OP_WRITE) || (d.operand != '0);
    ill = (mode_m != PRIV_MACHINE) || !hit || (wr && d.addr == `HSV_CSR_MHARTID);
    case (d.op)
      CSR_OP_SET:   nv = old | d.operand;
      CSR_OP_CLEAR: nv = old & ~d.operand;
      default:      nv = d.operand;
    endcase
    if (!ill && wr) model_write(d.addr, nv);
    checker0.push_expected(d.token, ill ? '0 : old, ill,
                           !ill && d.addr == `HSV_CSR_MCYCLE,
                           !ill && wr && d.addr == `HSV_CSR_MCYCLE,
                           (d.op == CSR_OP_WRITE) ? d.operand : '0);
    sent++;
    @(negedge clk_core);
    // the instruction is held until its result enters the skid buffer
    checker0.check_value("csr_ready_busy", 32'd0, word'(ready_o));
    while (checker0.received_count != sent) begin
      tick();
    end
  endtask

  // with_csr sends an instruction in the trap cycle that the flush must discard
  task automatic inject_trap(input logic with_csr);
    exception_t c;
    word v;
    word pc;
    c = 4'($urandom);
    v = $urandom;
    pc = $urandom & ~32'h3;
    // the discarded instruction needs an idle FSM so that the trap is taken at once
    if (with_csr) begin
      drain_flush();
    end
    ctrl_trap_cause_i <= c;
    ctrl_trap_value_i <= v;
    ctrl_next_pc_i <= pc;
    ctrl_trap_i <= 1'b1;
    if (with_csr) begin
      valid_i <= 1'b1;
      ctrlstatus_data_i <= random_insn(4'hF);
    end
    tick();
    valid_i <= 1'b0;
    @(negedge clk_core);
    if (with_csr) begin
      checker0.check_value("trap_flush_req", 32'd1, word'(flush_req_o));
    end
    // commit holds the trap while an earlier flush is still completing
    while (!flush_req_o) begin
      tick();
      @(negedge clk_core);
    end
    mepc_m = pc;
    mcause_m = word'(c);
    mtval_m = v;
    mpie_m = mie_m;
    mie_m = 1'b0;
    mpp_m = mode_m;
    mode_m = PRIV_MACHINE;
    checker0.check_value("trap_mode", word'(PRIV_MACHINE), word'(current_mode_o));
    checker0.check_value("trap_ready", 32'd0, word'(ready_o));
    checker0.check_value("trap_target", mtvec_m, flush_target_o);
    tick();
    ctrl_trap_i <= 1'b0;
    await_request_drop();
  endtask

  task automatic mode_return();
    ctrl_mode_return_i <= 1'b1;
    tick();
    @(negedge clk_core);
    while (!flush_req_o) begin
      tick();
      @(negedge clk_core);
    end
    mode_m = mpp_m;
    mie_m = mpie_m;
    mpp_m = PRIV_USER;
    checker0.check_value("mret_mode", word'(mode_m), word'(current_mode_o));
    checker0.check_value("mret_target", mepc_m, flush_target_o);
    tick();
    ctrl_mode_return_i <= 1'b0;
    await_request_drop();
  endtask

  initial begin
    void'($urandom(74959));
    reset_i = 1'b1;
    valid_i = 1'b0;
    ctrlstatus_data_i = '0;
    ready_i = 1'b0;
    ctrl_trap_i = 1'b0;
    ctrl_trap_cause_i = '0;
    ctrl_trap_value_i = '0;
    ctrl_next_pc_i = '0;
    ctrl_mode_return_i = 1'b0;
    ctrl_commit_i = 1'b0;
    mie_m = 1'b0;
    mpie_m = 1'b0;
    mpp_m = PRIV_USER;
    mode_m = PRIV_MACHINE;
    mtvec_m = '0;
    mepc_m = '0;
    mcause_m = '0;
    mtval_m = '0;
    mscratch_m = '0;
    minstret_m = '0;
    minstret_load = 1'b0;
    minstret_next = '0;
    repeat (2) @(posedge clk_core);
    reset_i <= 1'b0;
    for (int op = 0; op < NUM_OPS; op++) begin
      case ($urandom % 12)
        0:       inject_trap(1'b0);
        1:       inject_trap(1'b1);
        2:       mode_return();
        default: run_csr();
      endcase
    end
    repeat (5) tick();
    checker0.print_summary();
    if (checker0.error_count == 0 && checker0.received_count == sent) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- tb_ctrlstatus_checker.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module tb_ctrlstatus_checker
  import hsv_ctrlstatus_pkg::*;
(
  input  logic                         clk_core,
  input  logic                         reset_i,
  input  logic                         valid_o,
  input  logic                         ready_i,
  input  commit_data_t                 commit_data_o,
  input  logic                         flush_req_o,
  input  logic [`HSV_FLUSH_STAGES-1:0] flush_acks_i
);

  // any_value marks an mcycle read, which is only checked for growth
  typedef struct packed {
    insn_token token;
    word       old_value;
    logic      illegal;
    logic      any_value;
    logic      floor_set;
    word       floor;
  } expect_t;

  expect_t                      pending[$];
  int                           error_count = 0;
  int                           check_count = 0;
  int                           received_count = 0;
  word                          mcycle_floor = '0;
  logic                         req_q = 1'b0;
  logic [`HSV_FLUSH_STAGES-1:0] acks_q = '0;

  task automatic check_value(input string name, input word exp, input word act);
    check_count++;
    if (exp !== act) begin
      error_count++;
      $display("Fail %s: expected %08h, actual %08h", name, exp, act);
    end
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
  endtask

  task automatic push_expected(input insn_token token, input word old_value, input logic illegal,
                               input logic any_value, input logic floor_set, input word floor);
    pending.push_back('{token, old_value, illegal, any_value, floor_set, floor});
  endtask

  task automatic print_summary();
    $display("checker summary: %0d checks, %0d errors, %0d results outstanding",
             check_count, error_count, pending.size());
  endtask

  // outputs are sampled mid-cycle, a transfer seen here completes at the next rising edge
  always @(negedge clk_core) begin : watch
    expect_t e;
    if (!reset_i) begin
      if (valid_o && ready_i) begin
        received_count++;
        if (pending.size() == 0) begin
          report_error("a result arrived with no instruction outstanding");
        end else begin
          e = pending.pop_front();
          check_value("csr_token", word'(e.token), word'(commit_data_o.token));
          check_value("csr_illegal", word'(e.illegal), word'(commit_data_o.illegal));
          if (e.any_value) begin
            check_count++;
            if (commit_data_o.old_value <= mcycle_floor) begin
              error_count++;
              $display("Fail mcycle_increase: expected above %08h, actual %08h",
                       mcycle_floor, commit_data_o.old_value);
            end
            mcycle_floor = commit_data_o.old_value;
          end else begin
            check_value("csr_old_value", e.old_value, commit_data_o.old_value);
          end
          if (e.floor_set) begin
            mcycle_floor = e.floor;
          end
        end
      end
      if (req_q && !flush_req_o && acks_q != '1) begin
        report_error("flush request fell before all stage acks were high");
      end
      if (!req_q && flush_req_o && acks_q != '0) begin
        report_error("flush request rose while stage acks were still high");
      end
    end
    req_q = flush_req_o;
    acks_q = flush_acks_i;
  end

endmodule

//--- hsv_ctrlstatus.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module hsv_ctrlstatus
  import hsv_ctrlstatus_pkg::*;
(
  input  logic                         clk_core,
  input  logic                         reset_i,
  input  logic                         valid_i,
  output logic                         ready_o,
  input  ctrlstatus_data_t             ctrlstatus_data_i,
  output logic                         valid_o,
  input  logic                         ready_i,
  output commit_data_t                 commit_data_o,
  input  logic                         ctrl_trap_i,
  input  exception_t                   ctrl_trap_cause_i,
  input  word                          ctrl_trap_value_i,
  input  word                          ctrl_next_pc_i,
  input  logic                         ctrl_mode_return_i,
  input  logic                         ctrl_commit_i,
  output logic                         flush_req_o,
  output word                          flush_target_o,
  input  logic [`HSV_FLUSH_STAGES-1:0] flush_acks_i,
  output privilege_t                   current_mode_o
);

  logic [`HSV_FLUSH_STAGES:0] all_acks;
  logic         flush_ack;
  logic         flush_ack_rising;
  logic         flush_ack_falling;
  logic         rw_flush_ack;
  trap_update_t trap_update;
  csr_state_t   csr_state;
  csr_req_t     csr_req;
  csr_rsp_t     csr_rsp;
  logic [1:0]   cnt_wr;
  word          cnt_wr_data;
  word          mcycle;
  word          minstret;
  logic         rw_valid;
  logic         rw_ready;
  commit_data_t rw_result;

  assign all_acks = {flush_acks_i, rw_flush_ack};

  // while stages disagree the FSM must see the ack it is not waiting for
  assign flush_ack_rising = &all_acks;
  assign flush_ack_falling = |all_acks;
  assign flush_ack = flush_req_o ? flush_ack_rising : flush_ack_falling;

  hsv_ctrlstatus_trap_fsm global_fsm (
    .clk_core,
    .reset_i,
    .ctrl_trap_i,
    .ctrl_trap_cause_i,
    .ctrl_trap_value_i,
    .ctrl_next_pc_i,
    .ctrl_mode_return_i,
    .flush_ack_i(flush_ack),
    .csr_state_i(csr_state),
    .trap_update_o(trap_update),
    .flush_req_o,
    .flush_target_o,
    .current_mode_o
  );

  hsv_ctrlstatus_regs regs (
    .clk_core,
    .reset_i,
    .csr_req_i(csr_req),
    .csr_rsp_o(csr_rsp),
    .trap_update_i(trap_update),
    .csr_state_o(csr_state),
    .mcycle_i(mcycle),
    .minstret_i(minstret),
    .cnt_wr_o(cnt_wr),
    .cnt_wr_data_o(cnt_wr_data)
  );

  hsv_ctrlstatus_counters counters (
    .clk_core,
    .reset_i,
    .ctrl_commit_i,
    .cnt_wr_i(cnt_wr),
    .cnt_wr_data_i(cnt_wr_data),
    .mcycle_o(mcycle),
    .minstret_o(minstret)
  );

  hsv_ctrlstatus_readwrite readwrite (
    .clk_core,
    .reset_i,
    .valid_i,
    .ready_o,
    .ctrlstatus_data_i,
    .current_mode_i(current_mode_o),
    .flush_req_i(flush_req_o),
    .flush_ack_o(rw_flush_ack),
    .csr_req_o(csr_req),
    .csr_rsp_i(csr_rsp),
    .result_valid_o(rw_valid),
    .result_ready_i(rw_ready),
    .result_o(rw_result)
  );

  hsv_skid_buffer #(
    .payload_t(commit_data_t)
  ) ctrlstatus2commit (
    .clk_core,
    .reset_i,
    .flush_i(flush_req_o),
    .valid_i(rw_valid),
    .ready_o(rw_ready),
    .data_i(rw_result),
    .valid_o,
    .ready_i,
    .data_o(commit_data_o)
  );

endmodule

//--- hsv_ctrlstatus_trap_fsm.sv
`timescale 1ns/1ps

module hsv_ctrlstatus_trap_fsm
  import hsv_ctrlstatus_pkg::*;
(
  input  logic         clk_core,
  input  logic         reset_i,
  input  logic         ctrl_trap_i,
  input  exception_t   ctrl_trap_cause_i,
  input  word          ctrl_trap_value_i,
  input  word          ctrl_next_pc_i,
  input  logic         ctrl_mode_return_i,
  input  logic         flush_ack_i,
  input  csr_state_t   csr_state_i,
  output trap_update_t trap_update_o,
  output logic         flush_req_o,
  output word          flush_target_o,
  output privilege_t   current_mode_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RAISING,
    ST_FALLING
  } flush_state_t;

  flush_state_t state;
  privilege_t   mode;

  // requests are only taken while no flush is running, a trap beats an mret
  assign trap_update_o.trap = (state == ST_IDLE) & ctrl_trap_i;
  assign trap_update_o.mret = (state == ST_IDLE) & ctrl_mode_return_i & ~ctrl_trap_i;
  assign trap_update_o.mepc = ctrl_next_pc_i;
  assign trap_update_o.mcause = word'(ctrl_trap_cause_i);
  assign trap_update_o.mtval = ctrl_trap_value_i;
  assign trap_update_o.prev_mode = mode;

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      state <= ST_IDLE;
      mode <= PRIV_MACHINE;
    end else begin
      case (state)
        ST_IDLE: begin
          if (trap_update_o.trap) begin
            state <= ST_RAISING;
            mode <= PRIV_MACHINE;
          end else if (trap_update_o.mret) begin
            state <= ST_RAISING;
            mode <= csr_state_i.mpp;
          end
        end
        // the merged ack is the AND of all stages here
        ST_RAISING: if (flush_ack_i) state <= ST_FALLING;
        // and the OR of all stages once the request is low
        ST_FALLING: if (!flush_ack_i) state <= ST_IDLE;
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_core) begin
    if (trap_update_o.trap) begin
      flush_target_o <= csr_state_i.mtvec;
    end else if (trap_update_o.mret) begin
      flush_target_o <= csr_state_i.mepc;
    end
  end

  assign flush_req_o = (state == ST_RAISING);
  assign current_mode_o = mode;

endmodule

//--- hsv_ctrlstatus_readwrite.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module hsv_ctrlstatus_readwrite
  import hsv_ctrlstatus_pkg::*;
(
  input  logic             clk_core,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  ctrlstatus_data_t ctrlstatus_data_i,
  input  privilege_t       current_mode_i,
  input  logic             flush_req_i,
  output logic             flush_ack_o,
  output csr_req_t         csr_req_o,
  input  csr_rsp_t         csr_rsp_i,
  output logic             result_valid_o,
  input  logic             result_ready_i,
  output commit_data_t     result_o
);

  logic             busy;
  ctrlstatus_data_t insn;
  logic             is_write;
  logic             illegal;
  word              new_value;

  // one instruction at a time, the next is taken once the result has left
  assign ready_o = ~busy & ~flush_req_i;

  // csrrs and csrrc with a zero operand are pure reads
  assign is_write = (insn.op == CSR_OP_WRITE) || (insn.operand != '0);

  assign illegal = (current_mode_i != PRIV_MACHINE) || !csr_rsp_i.hit ||
                   (is_write && (insn.addr == `HSV_CSR_MHARTID));

  always_comb begin
    case (insn.op)
      CSR_OP_SET:   new_value = csr_rsp_i.rdata | insn.operand;
      CSR_OP_CLEAR: new_value = csr_rsp_i.rdata & ~insn.operand;
      default:      new_value = insn.operand;
    endcase
  end

  assign result_valid_o = busy & ~flush_req_i;

  // the access only fires when the result can move on, so a stall never repeats a write
  assign csr_req_o.valid = result_valid_o & result_ready_i;
  assign csr_req_o.addr = insn.addr;
  assign csr_req_o.write = is_write & ~illegal;
  assign csr_req_o.wdata = new_value;

  assign result_o.token = insn.token;
  assign result_o.old_value = illegal ? '0 : csr_rsp_i.rdata;
  assign result_o.illegal = illegal;

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      busy <= 1'b0;
      flush_ack_o <= 1'b0;
    end else begin
      flush_ack_o <= flush_req_i;
      if (flush_req_i) begin
        busy <= 1'b0;
      end else if (valid_i && ready_o) begin
        busy <= 1'b1;
      end else if (result_valid_o && result_ready_i) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_core) begin
    if (valid_i && ready_o) begin
      insn <= ctrlstatus_data_i;
    end
  end

endmodule

//--- hsv_ctrlstatus_counters.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module hsv_ctrlstatus_counters
  import hsv_ctrlstatus_pkg::*;
(
  input  logic       clk_core,
  input  logic       reset_i,
  input  logic       ctrl_commit_i,
  input  logic [1:0] cnt_wr_i,
  input  word        cnt_wr_data_i,
  output word        mcycle_o,
  output word        minstret_o
);

  logic [`HSV_CNT_WIDTH-1:0] mcycle_q;
  logic [`HSV_CNT_WIDTH-1:0] minstret_q;

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      mcycle_q <= '0;
      minstret_q <= '0;
    end else begin
      // a software write replaces the increment of that cycle
      if (cnt_wr_i[0]) begin
        mcycle_q <= cnt_wr_data_i;
      end else begin
        mcycle_q <= mcycle_q + 1'b1;
      end

      if (cnt_wr_i[1]) begin
        minstret_q <= cnt_wr_data_i;
      end else if (ctrl_commit_i) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

  assign mcycle_o = mcycle_q;
  assign minstret_o = minstret_q;

endmodule

//--- hsv_ctrlstatus_regs.sv
`timescale 1ns/1ps
`include "hsv_ctrlstatus_consts.svh"

module hsv_ctrlstatus_regs
  import hsv_ctrlstatus_pkg::*;
(
  input  logic         clk_core,
  input  logic         reset_i,
  input  csr_req_t     csr_req_i,
  output csr_rsp_t     csr_rsp_o,
  input  trap_update_t trap_update_i,
  output csr_state_t   csr_state_o,
  input  word          mcycle_i,
  input  word          minstret_i,
  output logic [1:0]   cnt_wr_o,
  output word          cnt_wr_data_o
);

  logic       mie;
  logic       mpie;
  privilege_t mpp;
  word        mtvec;
  word        mepc;
  word        mcause;
  word        mtval;
  word        mscratch;
  word        mstatus_view;
  logic       sw_we;

  // only mie, mpie and mpp are implemented, the other mstatus bits read as zero
  assign mstatus_view = {19'b0, mpp, 3'b0, mpie, 3'b0, mie, 3'b0};

  always_comb begin
    csr_rsp_o.hit = 1'b1;
    case (csr_req_i.addr)
      `HSV_CSR_MSTATUS:  csr_rsp_o.rdata = mstatus_view;
      `HSV_CSR_MTVEC:    csr_rsp_o.rdata = mtvec;
      `HSV_CSR_MEPC:     csr_rsp_o.rdata = mepc;
      `HSV_CSR_MCAUSE:   csr_rsp_o.rdata = mcause;
      `HSV_CSR_MTVAL:    csr_rsp_o.rdata = mtval;
      `HSV_CSR_MSCRATCH: csr_rsp_o.rdata = mscratch;
      `HSV_CSR_MCYCLE:   csr_rsp_o.rdata = mcycle_i;
      `HSV_CSR_MINSTRET: csr_rsp_o.rdata = minstret_i;
      `HSV_CSR_MHARTID:  csr_rsp_o.rdata = `HSV_HART_ID;
      default: begin
        csr_rsp_o.rdata = '0;
        csr_rsp_o.hit = 1'b0;
      end
    endcase
  end

  // a trap or mret in the same cycle wins over the software write
  assign sw_we = csr_req_i.valid & csr_req_i.write & csr_rsp_o.hit &
                 ~trap_update_i.trap & ~trap_update_i.mret;

  assign cnt_wr_o[0] = sw_we & (csr_req_i.addr == `HSV_CSR_MCYCLE);
  assign cnt_wr_o[1] = sw_we & (csr_req_i.addr == `HSV_CSR_MINSTRET);
  assign cnt_wr_data_o = csr_req_i.wdata;

  always_ff @(posedge clk_core) begin
    if (reset_i) begin
      mie <= 1'b0;
      mpie <= 1'b0;
      mpp <= PRIV_USER;
      mtvec <= '0;
      mepc <= '0;
      mcause <= '0;
      mtval <= '0;
      mscratch <= '0;
    end else if (trap_update_i.trap) begin
      mpie <= mie;
      mie <= 1'b0;
      mpp <= trap_update_i.prev_mode;
      mepc <= trap_update_i.mepc;
      mcause <= trap_update_i.mcause;
      mtval <= trap_update_i.mtval;
    end else if (trap_update_i.mret) begin
      mie <= mpie;
      mpp <= PRIV_USER;
    end else if (sw_we) begin
      case (csr_req_i.addr)
        `HSV_CSR_MSTATUS: begin
          mie <= csr_req_i.wdata[3];
          mpie <= csr_req_i.wdata[7];
          // unsupported modes fall back to user
          mpp <= (csr_req_i.wdata[12:11] == 2'b11) ? PRIV_MACHINE : PRIV_USER;
        end
        `HSV_CSR_MTVEC:    mtvec <= csr_req_i.wdata;
        `HSV_CSR_MEPC:     mepc <= csr_req_i.wdata;
        `HSV_CSR_MCAUSE:   mcause <= csr_req_i.wdata;
        `HSV_CSR_MTVAL:    mtval <= csr_req_i.wdata;
        `HSV_CSR_MSCRATCH: mscratch <= csr_req_i.wdata;
        default: ;
      endcase
    end
  end

  assign csr_state_o = '{mie: mie, mpie: mpie, mpp: mpp, mtvec: mtvec, mepc: mepc};

endmodule

//--- hsv_skid_buffer.sv
`timescale 1ns/1ps

module hsv_skid_buffer #(
  parameter type payload_t = logic
) (
  input  logic     clk_core,
  input  logic     reset_i,
  input  logic     flush_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     out_valid;
  logic     skid_valid;
  payload_t out_data;
  payload_t skid_data;
  logic     push;
  logic     pop;

  // ready depends only on state, so the producer never sees a combinational path
  assign ready_o = ~skid_valid;
  assign valid_o = out_valid;
  assign data_o = out_data;

  assign push = valid_i & ready_o;
  assign pop = out_valid & ready_i;

  always_ff @(posedge clk_core) begin
    if (reset_i || flush_i) begin
      out_valid <= 1'b0;
      skid_valid <= 1'b0;
    end else if (pop || !out_valid) begin
      // the skid entry drains first to keep the order
      out_valid <= skid_valid | push;
      skid_valid <= 1'b0;
    end else if (push) begin
      skid_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_core) begin
    if (pop || !out_valid) begin
      out_data <= skid_valid ? skid_data : data_i;
    end else if (push) begin
      skid_data <= data_i;
    end
  end

endmodule

//--- hsv_ctrlstatus_pkg.sv
`include "hsv_ctrlstatus_consts.svh"

package hsv_ctrlstatus_pkg;

  typedef logic [31:0] word;
  typedef logic [`HSV_CSR_ADDR_W-1:0] csr_addr_t;
  typedef logic [3:0] insn_token;
  typedef logic [3:0] exception_t;

  // encodings follow the mstatus.mpp field
  typedef enum logic [1:0] {
    PRIV_USER    = 2'b00,
    PRIV_MACHINE = 2'b11
  } privilege_t;

  typedef enum logic [1:0] {
    CSR_OP_WRITE = 2'b00,
    CSR_OP_SET   = 2'b01,
    CSR_OP_CLEAR = 2'b10
  } csr_op_t;

  typedef struct packed {
    csr_addr_t addr;
    csr_op_t   op;
    word       operand;
    insn_token token;
  } ctrlstatus_data_t;

  typedef struct packed {
    insn_token token;
    word       old_value;
    logic      illegal;
  } commit_data_t;

  typedef struct packed {
    logic      valid;
    csr_addr_t addr;
    logic      write;
    word       wdata;
  } csr_req_t;

  // hit is low for an address that maps to no register
  typedef struct packed {
    word  rdata;
    logic hit;
  } csr_rsp_t;

  // prev_mode is the mode the trap was taken from, it lands in mpp
  typedef struct packed {
    logic       trap;
    logic       mret;
    word        mepc;
    word        mcause;
    word        mtval;
    privilege_t prev_mode;
  } trap_update_t;

  typedef struct packed {
    logic       mie;
    logic       mpie;
    privilege_t mpp;
    word        mtvec;
    word        mepc;
  } csr_state_t;

endpackage

//--- hsv_ctrlstatus_consts.svh
`ifndef HSV_CTRLSTATUS_CONSTS_SVH
`define HSV_CTRLSTATUS_CONSTS_SVH

// width of a CSR address field in the instruction encoding
`define HSV_CSR_ADDR_W 12

// machine-mode CSR addresses as listed in the privileged spec
`define HSV_CSR_MSTATUS  12'h300
`define HSV_CSR_MTVEC    12'h305
`define HSV_CSR_MSCRATCH 12'h340
`define HSV_CSR_MEPC     12'h341
`define HSV_CSR_MCAUSE   12'h342
`define HSV_CSR_MTVAL    12'h343
`define HSV_CSR_MCYCLE   12'hB00
`define HSV_CSR_MINSTRET 12'hB02
`define HSV_CSR_MHARTID  12'hF14

// pipeline stages outside this unit that acknowledge a flush
`define HSV_FLUSH_STAGES 6

// value returned by a read of mhartid
`define HSV_HART_ID 32'd1

// only the low halves of mcycle and minstret exist
`define HSV_CNT_WIDTH 32

`endif
